//--- boot_req_stage.sv
//////////////////////////////////////////////////////////////////////
// Stage 1: captures one bus request at a time and runs the
// bootloader wait/done machine for the processor reset
//////////////////////////////////////////////////////////////////////
`default_nettype none

module boot_req_stage
   import u2_bus_pkg::*, u2_ctrl_pkg::*;
(
   input  wire               wb_clk,
   input  wire               wb_rst,
   input  wire               wb_cyc_i,
   input  wire               wb_stb_i,
   input  wire               wb_we_i,
   input  wire  [BUS_AW-1:0] wb_adr_i,
   input  wire  [BUS_DW-1:0] wb_dat_i,
   input  wire               bldr_done_i,
   input  wire               resp_done_i,   // Ack or err went out
   output logic              req_vld_o,
   output logic              req_we_o,
   output logic [BUS_AW-1:0] req_adr_o,
   output logic [BUS_DW-1:0] req_dat_o,
   output logic              cpu_rst_o,
   output logic [15:0]       cpu_sp_init_o
);

   boot_state_e state;
   logic        busy;
   logic        take;

   assign take = wb_cyc_i & wb_stb_i & ~busy;   // Held stb ignored while busy

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         busy      <= 1'b0;
         req_vld_o <= 1'b0;
      end else begin
         req_vld_o <= take;
         if (take)
            busy <= 1'b1;
         else if (resp_done_i)
            busy <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (take) begin
         req_we_o  <= wb_we_i;
         req_adr_o <= wb_adr_i;
         req_dat_o <= wb_dat_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bootloader hand-over, one restart pulse then done for good

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state     <= BOOT_WAIT;
         cpu_rst_o <= 1'b1;
      end else begin
         cpu_rst_o <= 1'b0;
         if (state == BOOT_WAIT && bldr_done_i) begin
            state     <= BOOT_DONE;
            cpu_rst_o <= 1'b1;   // Restart into the main program
         end
      end
   end

   assign cpu_sp_init_o = (state == BOOT_DONE) ? SP_INIT_MAIN : SP_INIT_BOOT;

endmodule

`default_nettype wire

//--- readback_resp_stage.sv
//////////////////////////////////////////////////////////////////////
// Stage 3: readback words, cycle counter, interrupt vector and
// the registered bus response
//////////////////////////////////////////////////////////////////////
`default_nettype none

module readback_resp_stage
   import u2_bus_pkg::*, u2_ctrl_pkg::*;
(
   input  wire               wb_clk,
   input  wire               wb_rst,
   input  wire               dec_vld_i,
   input  wire  bus_region_e dec_region_i,
   input  wire  wb_addr_u    dec_adr_i,
   input  wire               set_ack_i,
   input  wire               button_i,
   input  wire               clk_status_i,
   input  wire               serdes_link_up_i,
   input  wire               phy_intn_i,
   input  wire               sim_mode_i,
   input  wire  [3:0]        clock_divider_i,
   output logic              wb_ack_o,
   output logic [BUS_DW-1:0] wb_dat_o,
   output logic              wb_err_o
);

   logic [31:0] cycle_count;
   logic [31:0] irq;
   logic [31:0] rb_word;
   logic        rb_hit;

   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         cycle_count <= 32'd0;
      else
         cycle_count <= cycle_count + 32'd1;
   end

   // Sources that were dropped stay at zero
   assign irq = {18'd0, button_i, 1'b0, clk_status_i, serdes_link_up_i,
                 5'd0, phy_intn_i, 4'd0};

   always_comb begin
      case (dec_adr_i.rb.idx)
         RB_DIV:    rb_word = {sim_mode_i, 27'd0, clock_divider_i};
         RB_COMPAT: rb_word = COMPAT_NUM;
         RB_IRQ:    rb_word = irq;
         RB_CYCLES: rb_word = cycle_count;
         default:   rb_word = 32'd0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Bus response, one cycle after decode

   assign rb_hit = dec_vld_i & (dec_region_i == RGN_READBACK);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
      end else begin
         wb_ack_o <= rb_hit | set_ack_i;
         wb_err_o <= dec_vld_i & (dec_region_i == RGN_UNMAPPED);
      end
   end

   always_ff @(posedge wb_clk) begin
      if (dec_vld_i)
         wb_dat_o <= rb_hit ? rb_word : '0;   // Settings reads return 0
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the control bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_u2_core -f verilog.f -o sim_u2_core

status=0
./obj_dir/sim_u2_core > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Testbench passed" sim.log; then
   echo "Simulation did not finish cleanly"
   exit 1
fi
echo "Simulation OK"

//--- settings_regs.sv
//////////////////////////////////////////////////////////////////////
// Settings bus slave: write decode, the setting registers and
// the LED source mux
//////////////////////////////////////////////////////////////////////
`default_nettype none

module settings_regs
   import u2_bus_pkg::*, u2_ctrl_pkg::*;
(
   input  wire               wb_clk,
   input  wire               wb_rst,
   input  wire               dec_vld_i,
   input  wire  bus_region_e dec_region_i,
   input  wire               dec_we_i,
   input  wire  wb_addr_u    dec_adr_i,
   input  wire  [BUS_DW-1:0] dec_dat_i,
   input  wire               clk_status_i,
   input  wire               serdes_link_up_i,
   input  wire               run_rx_i,
   input  wire               run_tx_i,
   output logic              set_ack_o,
   output logic              bldr_done_o,
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   output logic              ser_enable_o,
   output logic              ser_prbsen_o,
   output logic              ser_loopen_o,
   output logic              ser_rx_en_o,
   output logic              adc_oe_a_o,
   output logic              adc_on_a_o,
   output logic              adc_oe_b_o,
   output logic              adc_on_b_o,
   output logic              phy_resetn_o,
   output logic [7:0]        leds_o
);

   logic       set_stb;
   logic [7:0] set_addr;
   logic [7:0] clk_reg;
   logic [7:0] ser_reg;
   logic [7:0] adc_reg;
   logic [7:0] led_sw;
   logic       phy_reg;
   logic       bldr_reg;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   assign set_ack_o = dec_vld_i & (dec_region_i == RGN_SETTINGS);   // Reads get ack too
   assign set_stb   = set_ack_o & dec_we_i;
   assign set_addr  = dec_adr_i.set.idx;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clk_reg  <= 8'd0;
         ser_reg  <= 8'd0;
         adc_reg  <= 8'd0;
         led_sw   <= 8'd0;
         phy_reg  <= 1'b0;
         bldr_reg <= 1'b0;
         led_src  <= LED_SRC_AT_RESET;
      end else if (set_stb) begin
         case (set_addr)
            SR_CLK:     clk_reg  <= dec_dat_i[7:0];
            SR_SER:     ser_reg  <= dec_dat_i[7:0];
            SR_ADC:     adc_reg  <= dec_dat_i[7:0];
            SR_LED_SW:  led_sw   <= dec_dat_i[7:0];
            SR_PHY:     phy_reg  <= dec_dat_i[0];
            SR_BLDR:    bldr_reg <= dec_dat_i[0];
            SR_LED_SRC: led_src  <= dec_dat_i[7:0];
            default: ;  // Unused setting addresses
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output control lines

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_reg[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_reg[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_reg[3:0];
   assign phy_resetn_o = ~phy_reg;
   assign bldr_done_o  = bldr_reg;

   // Mask bit set means hardware drives that LED
   assign led_hw = {3'd0, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

//--- tb_u2_core.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the radio core control bus: settings
// writes, LED mux, readback words, unmapped access and boot hand-over
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_u2_core
   import u2_bus_pkg::*, u2_ctrl_pkg::*;
();

   localparam int BUS_TIMEOUT  = 20;
   localparam int WAIT_TIMEOUT = 50;

   logic              wb_clk = 1'b0;
   logic              wb_rst;
   logic              wb_cyc_i, wb_stb_i, wb_we_i;
   logic [BUS_AW-1:0] wb_adr_i;
   logic [BUS_SW-1:0] wb_sel_i;
   logic [BUS_DW-1:0] wb_dat_i;
   logic [BUS_DW-1:0] wb_dat_o;
   logic              wb_ack_o, wb_err_o;
   logic              clk_status_i, serdes_link_up_i, run_rx_i, run_tx_i;
   logic              button_i, phy_intn_i, sim_mode_i;
   logic [3:0]        clock_divider_i;
   logic              cpu_rst_o;
   logic [15:0]       cpu_sp_init_o;
   logic              clock_ready_o;
   logic [1:0]        clk_en_o, clk_sel_o;
   logic              ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic              adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic              phy_resetn_o;
   logic [7:0]        leds_o;

   logic [31:0] lfsr = 32'h6a7d_25b1;
   logic [31:0] tb_cycles = 32'd0;    // Free-running reference count
   logic [31:0] ack_cycle;            // tb_cycles when the last response was seen
   int          rst_pulses = 0;

   u2_core_top dut0 (.*);

   always #2 wb_clk = ~wb_clk;

   always @(posedge wb_clk) tb_cycles <= tb_cycles + 32'd1;

   always @(posedge wb_clk) begin
      if (!wb_rst && cpu_rst_o)
         rst_pulses <= rst_pulses + 1;
   end

   //////////////////////////////////////////////////////////////////////
   // Error handling and compare tasks

   task automatic stop_run();
      $display("Testbench failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [BUS_DW-1:0] exp,
                             input logic [BUS_DW-1:0] act);
      if (act !== exp) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_ctrl(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         stop_run();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus and reference helpers

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [BUS_AW-1:0] set_adr(input logic [7:0] idx);
      return {REGION_SETTINGS, 2'b00, idx, 2'b00};
   endfunction

   function automatic logic [BUS_AW-1:0] rb_adr(input logic [3:0] idx);
      return {REGION_READBACK, 2'b00, idx, 2'b00};
   endfunction

   // status is {run_tx, run_rx, clk_status, serdes_link_up}
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                             input logic [3:0] status);
      logic [7:0] hw;
      logic [7:0] e;
      hw = {3'b000, status, 1'b0};
      for (int b = 0; b < 8; b++)
         e[b] = src[b] ? hw[b] : sw[b];
      return e;
   endfunction

   task automatic set_status(input logic [3:0] s);
      {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} = s;
   endtask

   // One bus cycle, stb held until ack or err, then dropped
   task automatic bus_cycle(input logic we, input logic [BUS_AW-1:0] adr,
                            input logic [BUS_DW-1:0] dat, output logic [BUS_DW-1:0] rdat,
                            output logic ack, output logic err, output logic [7:0] lat);
      int n;
      n = 0;
      @(negedge wb_clk);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      do begin
         @(negedge wb_clk);
         n++;
         if (n > BUS_TIMEOUT) begin
            $display("Timeout: no ack or err for address %h", adr);
            stop_run();
         end
      end while (!(wb_ack_o || wb_err_o));
      ack       = wb_ack_o;
      err       = wb_err_o;
      rdat      = wb_dat_o;
      lat       = 8'(n);
      ack_cycle = tb_cycles;
      wb_cyc_i  = 1'b0;
      wb_stb_i  = 1'b0;
      wb_we_i   = 1'b0;
      @(negedge wb_clk);
      if (wb_ack_o || wb_err_o) begin
         $display("Response pulse lasted more than one cycle at address %h", adr);
         stop_run();
      end
   endtask

   task automatic bus_write(input string name, input logic [7:0] idx,
                            input logic [BUS_DW-1:0] dat);
      logic [BUS_DW-1:0] rd;
      logic              ack, err;
      logic [7:0]        lat;
      bus_cycle(1'b1, set_adr(idx), dat, rd, ack, err, lat);
      check_flag({name, " ack"}, 1'b1, ack);
      check_flag({name, " err"}, 1'b0, err);
      check_ctrl({name, " latency"}, 8'd3, lat);
      check_word({name, " data"}, 32'd0, rd);   // Settings space returns 0
   endtask

   task automatic bus_read(input string name, input logic [3:0] idx,
                           output logic [BUS_DW-1:0] rd);
      logic       ack, err;
      logic [7:0] lat;
      bus_cycle(1'b0, rb_adr(idx), '0, rd, ack, err, lat);
      check_flag({name, " ack"}, 1'b1, ack);
      check_flag({name, " err"}, 1'b0, err);
      check_ctrl({name, " latency"}, 8'd3, lat);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests

   task automatic test_reset_values();
      check_ctrl("reset leds", led_expect(8'h1E, 8'h00, 4'b1010), leds_o);
      check_ctrl("reset clk", 8'd0, {3'b000, clock_ready_o, clk_en_o, clk_sel_o});
      check_ctrl("reset ser", 8'd0,
                 {4'd0, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o});
      check_ctrl("reset adc", 8'd0, {4'd0, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o});
      check_flag("reset phy_resetn", 1'b1, phy_resetn_o);
      check_word("reset sp_init", {16'd0, 16'h1FF8}, {16'd0, cpu_sp_init_o});
      check_flag("reset cpu_rst", 1'b0, cpu_rst_o);
   endtask

   task automatic test_settings_writes();
      logic [31:0] d;
      d = next_bits(32);
      bus_write("wr clk", 8'd0, d);
      check_ctrl("clk fields", {3'b000, d[4], d[3:2], d[1:0]},
                 {3'b000, clock_ready_o, clk_en_o, clk_sel_o});
      d = next_bits(32);
      bus_write("wr ser", 8'd1, d);
      check_ctrl("ser fields", {4'd0, d[3:0]},
                 {4'd0, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o});
      d = next_bits(32);
      bus_write("wr adc", 8'd2, d);
      check_ctrl("adc fields", {4'd0, d[3:0]},
                 {4'd0, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o});
      bus_write("wr phy", 8'd4, 32'd1);
      check_flag("phy held in reset", 1'b0, phy_resetn_o);
      bus_write("wr phy off", 8'd4, 32'd0);
      check_flag("phy released", 1'b1, phy_resetn_o);
   endtask

   task automatic test_led_mux();
      logic [31:0] r;
      logic [7:0]  sw, src;
      r   = next_bits(8);
      sw  = r[7:0];
      r   = next_bits(8);
      src = r[7:0];
      bus_write("wr led sw", 8'd3, {24'd0, sw});
      bus_write("wr led src", 8'd8, {24'd0, src});
      for (int p = 0; p < 16; p++) begin
         set_status(4'(p));
         @(negedge wb_clk);
         check_ctrl("led mux", led_expect(src, sw, 4'(p)), leds_o);
      end
   endtask

   task automatic test_readback();
      logic [31:0] rd, c0, c1, t0;
      bus_read("rb compat", 4'd12, rd);
      check_word("rb compat", 32'd4, rd);
      sim_mode_i      = 1'b1;
      clock_divider_i = 4'hA;
      bus_read("rb div a", 4'd9, rd);
      check_word("rb div a", {1'b1, 27'd0, 4'hA}, rd);
      sim_mode_i      = 1'b0;
      clock_divider_i = 4'h5;
      bus_read("rb div b", 4'd9, rd);
      check_word("rb div b", {1'b0, 27'd0, 4'h5}, rd);
      button_i     = 1'b1;
      phy_intn_i   = 1'b1;
      set_status(4'b0001);   // Only the link is up
      bus_read("rb irq a", 4'd13, rd);
      check_word("rb irq a", (32'd1 << 13) | (32'd1 << 10) | (32'd1 << 4), rd);
      button_i     = 1'b0;
      phy_intn_i   = 1'b0;
      set_status(4'b0010);   // Clock status only
      bus_read("rb irq b", 4'd13, rd);
      check_word("rb irq b", 32'd1 << 11, rd);
      bus_read("rb cycles a", 4'd15, c0);
      t0 = ack_cycle;
      repeat (25) @(negedge wb_clk);
      bus_read("rb cycles b", 4'd15, c1);
      check_word("rb cycles delta", ack_cycle - t0, c1 - c0);
   endtask

   task automatic test_unmapped();
      logic [31:0] rd;
      logic        ack, err;
      logic [7:0]  lat;
      bus_cycle(1'b0, 16'h6600, '0, rd, ack, err, lat);
      check_flag("unmapped ack", 1'b0, ack);
      check_flag("unmapped err", 1'b1, err);
      check_ctrl("unmapped latency", 8'd3, lat);
   endtask

   task automatic test_boot();
      int p0;
      int n;
      p0 = rst_pulses;
      n  = 0;
      bus_write("wr bldr", 8'd5, 32'd1);
      while (cpu_sp_init_o !== 16'hFFF8) begin
         @(negedge wb_clk);
         n++;
         if (n > WAIT_TIMEOUT) begin
            $display("Timeout: stack start value never switched to the main program");
            stop_run();
         end
      end
      repeat (10) @(negedge wb_clk);
      bus_write("wr bldr clear", 8'd5, 32'd0);
      bus_write("wr bldr again", 8'd5, 32'd1);
      repeat (10) @(negedge wb_clk);
      check_word("boot rst pulses", 32'd1, 32'(rst_pulses - p0));
      check_word("boot sp_init", {16'd0, 16'hFFF8}, {16'd0, cpu_sp_init_o});
   endtask

   initial begin
      wb_rst          = 1'b1;
      wb_cyc_i        = 1'b0;
      wb_stb_i        = 1'b0;
      wb_we_i         = 1'b0;
      wb_adr_i        = '0;
      wb_sel_i        = 4'hF;
      wb_dat_i        = '0;
      button_i        = 1'b0;
      phy_intn_i      = 1'b0;
      sim_mode_i      = 1'b0;
      clock_divider_i = 4'd0;
      set_status(4'b1010);   // run_tx and clk_status high
      repeat (16) @(negedge wb_clk);
      check_flag("cpu_rst in reset", 1'b1, cpu_rst_o);
      wb_rst = 1'b0;
      repeat (2) @(negedge wb_clk);
      test_reset_values();
      test_settings_writes();
      test_led_mux();
      test_readback();
      test_unmapped();
      test_boot();
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_u2_core_assertions.sv
//////////////////////////////////////////////////////////////////////
// Bound checks on the bus response pulses and the processor reset
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_u2_core_assertions #(
   parameter bit RESP_SIDE = 1'b1   // Response pulses, else boot reset
) (
   input wire wb_clk,
   input wire wb_rst,
   input wire ack_i,
   input wire err_i,
   input wire rst_pulse_i
);

   if (RESP_SIDE) begin : g_resp
      resp_excl: assert property (@(posedge wb_clk) disable iff (wb_rst) !(ack_i && err_i))
         else $error("ack and err high in the same cycle");

      ack_single: assert property (@(posedge wb_clk) disable iff (wb_rst) ack_i |=> !ack_i)
         else $error("ack held for more than one cycle");

      err_single: assert property (@(posedge wb_clk) disable iff (wb_rst) err_i |=> !err_i)
         else $error("err held for more than one cycle");
   end else begin : g_boot
      // Boot restart is a single pulse
      rst_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
                                   rst_pulse_i |=> !rst_pulse_i)
         else $error("cpu reset held for more than one cycle outside reset");
   end

endmodule

bind readback_resp_stage tb_u2_core_assertions #(.RESP_SIDE(1'b1)) resp_checks (
   .wb_clk(wb_clk), .wb_rst(wb_rst),
   .ack_i(wb_ack_o), .err_i(wb_err_o), .rst_pulse_i(1'b0));

bind boot_req_stage tb_u2_core_assertions #(.RESP_SIDE(1'b0)) boot_checks (
   .wb_clk(wb_clk), .wb_rst(wb_rst),
   .ack_i(1'b0), .err_i(1'b0), .rst_pulse_i(cpu_rst_o));

`default_nettype wire

//--- u2_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// System bus widths, address region codes and the two decoded
// views of one bus address word
//////////////////////////////////////////////////////////////////////
`default_nettype none

package u2_bus_pkg;

   localparam int BUS_DW = 32;
   localparam int BUS_AW = 16;   // 64K byte address space
   localparam int BUS_SW = 4;    // Byte lanes of a data word

   localparam logic [3:0] REGION_SETTINGS = 4'h5;    // 20K to 24K
   localparam logic [7:0] REGION_READBACK = 8'h63;

   // One address word, read as settings access or readback access
   typedef union packed {
      logic [BUS_AW-1:0] raw;
      struct packed {
         logic [3:0] region;
         logic [1:0] pad;
         logic [7:0] idx;     // Setting address
         logic [1:0] lane;
      } set;
      struct packed {
         logic [7:0] page;
         logic [1:0] pad;
         logic [3:0] idx;     // Readback word
         logic [1:0] lane;
      } rb;
   } wb_addr_u;

   typedef enum logic [1:0] {
      RGN_SETTINGS = 2'd0,
      RGN_READBACK = 2'd1,
      RGN_UNMAPPED = 2'd2
   } bus_region_e;

endpackage

`default_nettype wire

//--- u2_core_top.sv
//////////////////////////////////////////////////////////////////////
// Radio core control bus, three registered stages from bus
// request to response
//////////////////////////////////////////////////////////////////////
`default_nettype none

module u2_core_top
   import u2_bus_pkg::*;
(
   input  wire               wb_clk,
   input  wire               wb_rst,
   // System bus
   input  wire               wb_cyc_i,
   input  wire               wb_stb_i,
   input  wire               wb_we_i,
   input  wire  [BUS_AW-1:0] wb_adr_i,
   input  wire  [BUS_SW-1:0] wb_sel_i,   // Full-word accesses only
   input  wire  [BUS_DW-1:0] wb_dat_i,
   output logic [BUS_DW-1:0] wb_dat_o,
   output logic              wb_ack_o,
   output logic              wb_err_o,
   // Status inputs
   input  wire               clk_status_i,
   input  wire               serdes_link_up_i,
   input  wire               run_rx_i,
   input  wire               run_tx_i,
   input  wire               button_i,
   input  wire               phy_intn_i,
   input  wire               sim_mode_i,
   input  wire  [3:0]        clock_divider_i,
   // Processor boot
   output logic              cpu_rst_o,
   output logic [15:0]       cpu_sp_init_o,
   // Control lines
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   output logic              ser_enable_o,
   output logic              ser_prbsen_o,
   output logic              ser_loopen_o,
   output logic              ser_rx_en_o,
   output logic              adc_oe_a_o,
   output logic              adc_on_a_o,
   output logic              adc_oe_b_o,
   output logic              adc_on_b_o,
   output logic              phy_resetn_o,
   output logic [7:0]        leds_o
);

   logic              req_vld;
   logic              req_we;
   logic [BUS_AW-1:0] req_adr;
   logic [BUS_DW-1:0] req_dat;
   logic              dec_vld;
   bus_region_e       dec_region;
   logic              dec_we;
   wb_addr_u          dec_adr;
   logic [BUS_DW-1:0] dec_dat;
   logic              set_ack;
   logic              bldr_done;

   boot_req_stage boot_req_stage0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .bldr_done_i(bldr_done), .resp_done_i(wb_ack_o | wb_err_o),
      .req_vld_o(req_vld), .req_we_o(req_we), .req_adr_o(req_adr), .req_dat_o(req_dat),
      .cpu_rst_o(cpu_rst_o), .cpu_sp_init_o(cpu_sp_init_o));

   wb_addr_decode wb_addr_decode0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_vld_i(req_vld), .req_we_i(req_we), .req_adr_i(req_adr), .req_dat_i(req_dat),
      .dec_vld_o(dec_vld), .dec_region_o(dec_region), .dec_we_o(dec_we),
      .dec_adr_o(dec_adr), .dec_dat_o(dec_dat));

   settings_regs settings_regs0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .dec_vld_i(dec_vld), .dec_region_i(dec_region), .dec_we_i(dec_we),
      .dec_adr_i(dec_adr), .dec_dat_i(dec_dat),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .set_ack_o(set_ack), .bldr_done_o(bldr_done),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o));

   readback_resp_stage readback_resp_stage0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .dec_vld_i(dec_vld), .dec_region_i(dec_region), .dec_adr_i(dec_adr),
      .set_ack_i(set_ack),
      .button_i(button_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .phy_intn_i(phy_intn_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o), .wb_err_o(wb_err_o));

endmodule

`default_nettype wire

//--- u2_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Control side constants: setting addresses, readback words,
// compatibility number and boot stack values
//////////////////////////////////////////////////////////////////////
`default_nettype none

package u2_ctrl_pkg;

   //////////////////////////////////////////////////////////////////////
   // Setting register addresses

   localparam logic [7:0] SR_CLK     = 8'd0;
   localparam logic [7:0] SR_SER     = 8'd1;
   localparam logic [7:0] SR_ADC     = 8'd2;
   localparam logic [7:0] SR_LED_SW  = 8'd3;
   localparam logic [7:0] SR_PHY     = 8'd4;
   localparam logic [7:0] SR_BLDR    = 8'd5;   // Written by the bootloader
   localparam logic [7:0] SR_LED_SRC = 8'd8;

   // LEDs 4..1 follow hardware status out of reset
   localparam logic [7:0] LED_SRC_AT_RESET = 8'h1E;

   //////////////////////////////////////////////////////////////////////
   // Readback word indices

   localparam logic [3:0] RB_DIV    = 4'd9;
   localparam logic [3:0] RB_COMPAT = 4'd12;
   localparam logic [3:0] RB_IRQ    = 4'd13;
   localparam logic [3:0] RB_CYCLES = 4'd15;

   // Bumped whenever the register map changes
   localparam logic [31:0] COMPAT_NUM = 32'd4;

   // Stack start, top of boot RAM and top of its remapped copy
   localparam logic [15:0] SP_INIT_BOOT = 16'h1FF8;
   localparam logic [15:0] SP_INIT_MAIN = 16'hFFF8;

   typedef enum logic {
      BOOT_WAIT = 1'b0,
      BOOT_DONE = 1'b1
   } boot_state_e;

endpackage

`default_nettype wire

//--- verilog.f
u2_bus_pkg.sv
u2_ctrl_pkg.sv
boot_req_stage.sv
wb_addr_decode.sv
settings_regs.sv
readback_resp_stage.sv
u2_core_top.sv
tb_u2_core_assertions.sv
tb_u2_core.sv

//--- wb_addr_decode.sv
//////////////////////////////////////////////////////////////////////
// Stage 2: sorts the captured request into settings, readback
// or unmapped space and registers it with its region
//////////////////////////////////////////////////////////////////////
`default_nettype none

module wb_addr_decode
   import u2_bus_pkg::*;
(
   input  wire               wb_clk,
   input  wire               wb_rst,
   input  wire               req_vld_i,
   input  wire               req_we_i,
   input  wire  [BUS_AW-1:0] req_adr_i,
   input  wire  [BUS_DW-1:0] req_dat_i,
   output logic              dec_vld_o,
   output bus_region_e       dec_region_o,
   output logic              dec_we_o,
   output wb_addr_u          dec_adr_o,
   output logic [BUS_DW-1:0] dec_dat_o
);

   wb_addr_u    adr;
   bus_region_e region;

   assign adr.raw = req_adr_i;

   // Settings nibble covers 4K, readback page is 256 bytes
   always_comb begin
      if (adr.set.region == REGION_SETTINGS)
         region = RGN_SETTINGS;
      else if (adr.rb.page == REGION_READBACK)
         region = RGN_READBACK;
      else
         region = RGN_UNMAPPED;
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         dec_vld_o <= 1'b0;
      else
         dec_vld_o <= req_vld_i;
   end

   always_ff @(posedge wb_clk) begin
      if (req_vld_i) begin
         dec_region_o <= region;
         dec_we_o     <= req_we_i;
         dec_adr_o    <= adr;
         dec_dat_o    <= req_dat_i;
      end
   end

endmodule

`default_nettype wire
